// ==== include/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

//////////////////////////////////////////////////
// build-time fetch configuration
//////////////////////////////////////////////////

// first pc after reset, must sit on a line boundary
`define FETCH_RESET_VECTOR 64'h0000_0000_0000_0100

// number of icache lines, power of two
`define ICACHE_SETS 32

// byte address width of the fetch path
`define FETCH_ADDR_BITS 64

// byte offset bits inside one 64-bit line
`define ICACHE_OFFSET_BITS 3

`endif

// ==== hw/fetch_pkg.sv ====
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

	//////////////////////////////////////////////////
	// widths with a meaning
	//////////////////////////////////////////////////

	typedef logic [`FETCH_ADDR_BITS-1:0] addr_t;	// byte address
	typedef logic [31:0] inst_t;	// one alpha instruction
	typedef logic [63:0] line_t;	// two instructions, lower address in low half
	typedef logic [5:0] opcode_t;	// major opcode field, bits 31:26
	typedef logic [20:0] disp_t;	// branch displacement in words

	//////////////////////////////////////////////////
	// fetch packet
	//////////////////////////////////////////////////

	typedef struct packed {
		logic valid;	// slot carries an instruction
		addr_t pc;	// address the instruction came from
		inst_t inst;
	} fetch_slot_t;

	// slot0 is always the older instruction
	typedef struct packed {
		fetch_slot_t slot1;
		fetch_slot_t slot0;
	} fetch_packet_t;

	// unconditional branch info for both halves of the line
	typedef struct packed {
		logic jump0;	// low word is br or bsr
		logic jump1;	// high word is br or bsr
		addr_t target0;
		addr_t target1;
	} predecode_t;

	// icache refill fsm
	typedef enum logic [1:0] {
		REFILL_IDLE,
		REFILL_REQUEST,
		REFILL_WAIT_FILL
	} refill_state_t;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_stage (
	input wire logic clock,
	input wire logic reset,
	input wire logic stall,	// merged backend stall
	input wire logic redirect,	// one-cycle strobe from backend
	input wire fetch_pkg::addr_t redirect_pc,
	input wire logic hit,	// icache hit for fetch_pc, same cycle
	input wire fetch_pkg::line_t line,	// line read at fetch_pc
	input wire fetch_pkg::predecode_t predecode,
	output fetch_pkg::addr_t fetch_pc,
	output fetch_pkg::fetch_packet_t packet
);
	import fetch_pkg::*;

	addr_t pc;	// current fetch address
	addr_t next_pc;
	fetch_packet_t next_packet;
	logic fetch_fire;	// a fetch cycle happens this cycle
	inst_t low_inst;	// word at line offset 0
	inst_t high_inst;	// word at line offset 4

	assign fetch_pc = pc;
	assign low_inst = line[31:0];
	assign high_inst = line[63:32];

	// only fetch when the line is there and the backend has room
	assign fetch_fire = hit && !stall && !redirect;

	//////////////////////////////////////////////////
	// next pc and packet selection
	//////////////////////////////////////////////////

	always_comb
	begin
		next_pc = pc;	// hold by default (miss or stall)
		next_packet = '0;	// no slot unless a fetch fires

		if (redirect)
		begin
			// redirect wins over everything, packet stays empty
			next_pc = redirect_pc;
		end
		else if (fetch_fire)
		begin
			if (!pc[2])
			begin
				// aligned pc, both words are candidates
				next_packet.slot0.valid = 1'b1;
				next_packet.slot0.pc = pc;
				next_packet.slot0.inst = low_inst;
				if (predecode.jump0)
				begin
					// taken jump in slot0 kills slot1
					next_pc = predecode.target0;
				end
				else
				begin
					next_packet.slot1.valid = 1'b1;
					next_packet.slot1.pc = pc + addr_t'(4);
					next_packet.slot1.inst = high_inst;
					if (predecode.jump1)
						next_pc = predecode.target1;	// jump in slot1, both slots kept
					else
						next_pc = pc + addr_t'(8);	// straight line
				end
			end
			else
			begin
				// odd word, only the high half is ours
				next_packet.slot0.valid = 1'b1;
				next_packet.slot0.pc = pc;
				next_packet.slot0.inst = high_inst;
				if (predecode.jump1)
					next_pc = predecode.target1;
				else
					next_pc = pc + addr_t'(4);	// lands on the next line
			end
		end
	end

	//////////////////////////////////////////////////
	// pc and packet registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= `FETCH_RESET_VECTOR;
			packet.slot0.valid <= 1'b0;	// no packet out of reset
			packet.slot1.valid <= 1'b0;
		end
		else
		begin
			pc <= next_pc;
			packet <= next_packet;	// one-cycle packet, no hold on stall
		end
	end

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module icache (
	input wire logic clock,
	input wire logic reset,
	input wire fetch_pkg::addr_t fetch_pc,	// lookup address from fetch
	input wire logic mem_response,	// fill strobe from memory
	input wire fetch_pkg::line_t mem_line,	// fill data, valid with mem_response
	output logic hit,
	output fetch_pkg::line_t line,
	output logic mem_request,	// one-cycle refill strobe
	output fetch_pkg::addr_t mem_addr	// line aligned refill address
);
	import fetch_pkg::*;

	localparam int OFFSET_BITS = `ICACHE_OFFSET_BITS;
	localparam int INDEX_BITS = $clog2(`ICACHE_SETS);
	localparam int TAG_BITS = `FETCH_ADDR_BITS - INDEX_BITS - OFFSET_BITS;
	localparam int LINE_ADDR_BITS = `FETCH_ADDR_BITS - OFFSET_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;	// set select
	typedef logic [TAG_BITS-1:0] tag_t;	// upper address bits kept per line
	typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;	// address without byte offset

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	line_t data_array [`ICACHE_SETS];
	tag_t tag_array [`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] valid_array;	// one valid bit per line

	refill_state_t state;
	line_addr_t miss_line_addr;	// latched when the miss is taken

	index_t lookup_index;
	tag_t lookup_tag;
	index_t fill_index;
	tag_t fill_tag;
	logic fill_write;	// line write this cycle

	//////////////////////////////////////////////////
	// lookup, combinational
	//////////////////////////////////////////////////

	assign lookup_index = fetch_pc[OFFSET_BITS +: INDEX_BITS];
	assign lookup_tag = fetch_pc[`FETCH_ADDR_BITS-1 -: TAG_BITS];

	assign line = data_array[lookup_index];
	assign hit = valid_array[lookup_index] && (tag_array[lookup_index] == lookup_tag);

	// refill side always works from the latched miss address
	assign fill_index = miss_line_addr[INDEX_BITS-1:0];
	assign fill_tag = miss_line_addr[LINE_ADDR_BITS-1 -: TAG_BITS];
	assign fill_write = (state == REFILL_WAIT_FILL) && mem_response;

	assign mem_addr = {miss_line_addr, {OFFSET_BITS{1'b0}}};	// aligned by construction
	assign mem_request = (state == REFILL_REQUEST);	// request state lasts one cycle

	//////////////////////////////////////////////////
	// refill fsm
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= REFILL_IDLE;
		else
		begin
			case (state)
				REFILL_IDLE:
				begin
					if (!hit)
						state <= REFILL_REQUEST;	// strobe goes out next cycle
				end
				REFILL_REQUEST:
				begin
					state <= REFILL_WAIT_FILL;
				end
				REFILL_WAIT_FILL:
				begin
					// finishes even if fetch was redirected meanwhile
					if (mem_response)
						state <= REFILL_IDLE;
				end
				default:
				begin
					state <= REFILL_IDLE;
				end
			endcase
		end
	end

	// capture the missing line address as the fsm leaves idle
	always_ff @(posedge clock)
	begin
		if ((state == REFILL_IDLE) && !hit)
			miss_line_addr <= fetch_pc[`FETCH_ADDR_BITS-1:OFFSET_BITS];
	end

	//////////////////////////////////////////////////
	// line fill
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			valid_array <= '0;	// cache starts empty
		else if (fill_write)
			valid_array[fill_index] <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (fill_write)
		begin
			data_array[fill_index] <= mem_line;
			tag_array[fill_index] <= fill_tag;
		end
	end

endmodule

`default_nettype wire

// ==== hw/branch_predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module branch_predecode (
	input wire fetch_pkg::addr_t fetch_pc,	// current fetch address
	input wire fetch_pkg::line_t line,	// line read at fetch_pc
	output fetch_pkg::predecode_t predecode
);
	import fetch_pkg::*;

	localparam opcode_t OPCODE_BR = 6'h30;	// alpha br
	localparam opcode_t OPCODE_BSR = 6'h34;	// alpha bsr

	addr_t line_pc;	// address of the low word
	addr_t high_pc;	// address of the high word
	inst_t low_inst;
	inst_t high_inst;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// br and bsr share the branch format
	function automatic logic is_uncond_jump(input inst_t inst);
		opcode_t opcode;
		opcode = inst[31:26];
		return (opcode == OPCODE_BR) || (opcode == OPCODE_BSR);
	endfunction

	// target is slot pc + 4 + 4 * sign extended displacement
	function automatic addr_t jump_target(input addr_t slot_pc, input inst_t inst);
		disp_t disp;
		addr_t offset;
		disp = inst[20:0];
		offset = {{(`FETCH_ADDR_BITS-23){disp[20]}}, disp, 2'b00};
		return slot_pc + addr_t'(4) + offset;
	endfunction

	//////////////////////////////////////////////////
	// decode both halves
	//////////////////////////////////////////////////

	assign line_pc = {fetch_pc[`FETCH_ADDR_BITS-1:3], 3'b000};	// drop word and byte offset
	assign high_pc = line_pc + addr_t'(4);
	assign low_inst = line[31:0];
	assign high_inst = line[63:32];

	assign predecode.jump0 = is_uncond_jump(low_inst);
	assign predecode.jump1 = is_uncond_jump(high_inst);
	assign predecode.target0 = jump_target(line_pc, low_inst);
	assign predecode.target1 = jump_target(high_pc, high_inst);	// also used for odd pc

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit (
	input wire logic clock,
	input wire logic reset,
	input wire logic stall,	// backend cannot take a packet
	input wire logic redirect,	// backend restarts fetch
	input wire fetch_pkg::addr_t redirect_pc,
	input wire logic mem_response,
	input wire fetch_pkg::line_t mem_line,
	output logic mem_request,
	output fetch_pkg::addr_t mem_addr,
	output fetch_pkg::fetch_packet_t packet
);
	import fetch_pkg::*;

	//////////////////////////////////////////////////
	// internal nets
	//////////////////////////////////////////////////

	addr_t fetch_pc;	// pc from fetch_stage to icache and predecode
	logic hit;
	line_t line;	// icache read data
	predecode_t predecode;	// jump info back to fetch_stage

	fetch_stage fetch_stage_i (
		.clock (clock),
		.reset (reset),
		.stall (stall),
		.redirect (redirect),
		.redirect_pc (redirect_pc),
		.hit (hit),
		.line (line),
		.predecode (predecode),
		.fetch_pc (fetch_pc),
		.packet (packet)
	);

	icache icache_i (
		.clock (clock),
		.reset (reset),
		.fetch_pc (fetch_pc),
		.mem_response (mem_response),
		.mem_line (mem_line),
		.hit (hit),
		.line (line),
		.mem_request (mem_request),
		.mem_addr (mem_addr)
	);

	// purely combinational, same cycle as the lookup
	branch_predecode branch_predecode_i (
		.fetch_pc (fetch_pc),
		.line (line),
		.predecode (predecode)
	);

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running clock and a synchronous reset held for a few cycles
module clock_gen #(
	parameter int HALF_PERIOD = 10,	// ns, gives a 20 ns period
	parameter int RESET_CYCLES = 8
) (
	output logic clock,
	output logic reset
);
	initial
	begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;	// released on an edge like any other sync input
	end

endmodule

`default_nettype wire

// ==== test/fetch_unit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_assertions (
	input wire logic clock,
	input wire logic reset,
	input wire logic mem_request,
	input wire fetch_pkg::addr_t mem_addr,
	input wire fetch_pkg::fetch_packet_t packet
);

	//////////////////////////////////////////////////
	// memory port protocol
	//////////////////////////////////////////////////

	// refill strobe is a single cycle pulse
	request_one_cycle: assert property (@(posedge clock) disable iff (reset)
		mem_request |=> !mem_request)
		else $error("mem_request held for more than one cycle");

	request_aligned: assert property (@(posedge clock) disable iff (reset)
		mem_request |-> (mem_addr[2:0] == 3'b000))	// whole 64-bit lines only
		else $error("mem_addr not line aligned");

	//////////////////////////////////////////////////
	// packet shape
	//////////////////////////////////////////////////

	slot1_needs_slot0: assert property (@(posedge clock) disable iff (reset)
		!(packet.slot1.valid && !packet.slot0.valid))
		else $error("slot1 valid without slot0 valid");

endmodule

bind fetch_unit fetch_unit_assertions fetch_unit_assertions_i (
	.clock (clock),
	.reset (reset),
	.mem_request (mem_request),
	.mem_addr (mem_addr),
	.packet (packet)
);

`default_nettype wire

// ==== test/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit_tb;
	import fetch_pkg::*;

	localparam int MEM_LINES = 256;
	localparam int RESET_CYCLES = 8;
	localparam int PHASE_SLOTS = 120;	// slots for the straight and stall phases
	localparam int REDIRECTS = 5;
	localparam int REDIRECT_SLOTS = 32;	// slots followed after each redirect
	localparam int CYCLES_PER_SLOT = 10;	// worst miss share plus stalls
	localparam int WATCHDOG_CYCLES =
		CYCLES_PER_SLOT * (2 * PHASE_SLOTS + REDIRECTS * REDIRECT_SLOTS);
	localparam int REF_DEPTH = 512;	// reference entries per segment
	localparam opcode_t OP_BR = 6'h30;
	localparam opcode_t OP_BSR = 6'h34;

	logic clock;
	logic reset;
	logic stall = 1'b0;
	logic redirect = 1'b0;
	addr_t redirect_pc = '0;
	logic mem_response = 1'b0;
	line_t mem_line = '0;
	logic mem_request;
	addr_t mem_addr;
	fetch_packet_t packet;

	line_t mem_image [MEM_LINES];	// index is addr[10:3], higher bits alias
	addr_t exp_pc [$];	// reference stream, oldest first
	inst_t exp_inst [$];
	addr_t last_pc;	// reference entry consumed last
	inst_t last_inst;
	int unsigned stim_seed = 75;
	int unsigned delay_seed = 75;	// own stream for memory latency
	int slots_checked = 0;
	string test_name = "reset";
	logic pending = 1'b0;	// refill in flight
	addr_t pending_addr;
	int delay_left;

	clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
		.clock (clock),
		.reset (reset)
	);

	fetch_unit fetch_unit_i (
		.clock (clock),
		.reset (reset),
		.stall (stall),
		.redirect (redirect),
		.redirect_pc (redirect_pc),
		.mem_response (mem_response),
		.mem_line (mem_line),
		.mem_request (mem_request),
		.mem_addr (mem_addr),
		.packet (packet)
	);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic int unsigned lcg_next(inout int unsigned state);
		state = state * 32'd1103515245 + 32'd12345;
		return state;
	endfunction

	function automatic inst_t image_word(input addr_t pc);
		line_t l;
		l = mem_image[pc[10:3]];
		return pc[2] ? l[63:32] : l[31:0];	// low address in low half
	endfunction

	function automatic logic is_jump(input inst_t inst);
		return (inst[31:26] == OP_BR) || (inst[31:26] == OP_BSR);
	endfunction

	function automatic addr_t jump_dest(input addr_t pc, input inst_t inst);
		addr_t disp;
		disp = {{(`FETCH_ADDR_BITS-21){inst[20]}}, inst[20:0]};
		return pc + addr_t'(4) + (disp << 2);
	endfunction

	// slot by slot, a jump sends the next slot to its target
	function automatic void build_reference(input addr_t start_pc);
		addr_t pc;
		inst_t inst;
		exp_pc.delete();
		exp_inst.delete();
		pc = start_pc;
		for (int i = 0; i < REF_DEPTH; i++)
		begin
			inst = image_word(pc);
			exp_pc.push_back(pc);
			exp_inst.push_back(inst);
			pc = is_jump(inst) ? jump_dest(pc, inst) : pc + addr_t'(4);
		end
	endfunction

	function automatic addr_t random_target();
		int unsigned r;
		r = lcg_next(stim_seed);
		return addr_t'({r[23:16], r[24], 2'b00});	// any line, either word
	endfunction

	task automatic place_jump(input addr_t at, input addr_t target, input opcode_t opcode);
		longint disp;
		inst_t inst;
		disp = (longint'(target) - longint'(at) - 4) >>> 2;
		inst = {opcode, 5'd26, disp[20:0]};	// ra = r26
		mem_image[at[10:3]][at[2]*32 +: 32] = inst;
	endtask

	task automatic fill_image();
		int unsigned r;
		inst_t word;
		for (int i = 0; i < MEM_LINES; i++)
		begin
			for (int h = 0; h < 2; h++)
			begin
				r = lcg_next(stim_seed);
				word[31:16] = r[31:16];
				r = lcg_next(stim_seed);
				word[15:0] = r[31:16];
				if (is_jump(word))
					word[27] = ~word[27];	// 0x30 -> 0x32, 0x34 -> 0x36
				mem_image[i][h*32 +: 32] = word;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic compare_addr(input string name, input addr_t expected, input addr_t actual);
		if (actual !== expected)
			stop_with_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic compare_inst(input string name, input inst_t expected, input inst_t actual);
		if (actual !== expected)
			stop_with_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic compare_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stop_with_failure($sformatf("error %s: expected %b, actual %b", name, expected, actual));
	endtask

	task automatic check_slot(input string name, input fetch_slot_t slot);
		if (exp_pc.size() == 0)
			stop_with_failure("the reference stream ran out of expected slots");
		else
		begin
			last_pc = exp_pc.pop_front();
			last_inst = exp_inst.pop_front();
			compare_addr($sformatf("%s %s pc", test_name, name), last_pc, slot.pc);
			compare_inst($sformatf("%s %s inst", test_name, name), last_inst, slot.inst);
			slots_checked++;
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clock)
	begin
		if (reset)
		begin
			compare_valid("reset mem_request", 1'b0, mem_request);
			compare_valid("reset slot0 valid", 1'b0, packet.slot0.valid);
		end
		else
		begin
			if (packet.slot0.valid)
			begin
				check_slot("slot0", packet.slot0);
				// pair only from an even word that is not a jump
				compare_valid({test_name, " slot1 valid"}, !last_pc[2] && !is_jump(last_inst),
					packet.slot1.valid);
				if (packet.slot1.valid)
					check_slot("slot1", packet.slot1);
			end
			if (redirect)
				build_reference(redirect_pc);	// old path ends with this cycle's packet
		end
	end

	//////////////////////////////////////////////////
	// memory model, 2 to 6 cycles per refill
	//////////////////////////////////////////////////

	always @(posedge clock)
	begin
		mem_response <= 1'b0;
		if (reset)
			pending <= 1'b0;
		else if (mem_request)
		begin
			pending <= 1'b1;
			pending_addr <= mem_addr;
			delay_left <= 2 + int'(lcg_next(delay_seed) >> 16) % 5;
		end
		else if (pending)
		begin
			if (delay_left <= 1)
			begin
				mem_response <= 1'b1;
				mem_line <= mem_image[pending_addr[10:3]];
				pending <= 1'b0;
			end
			else
				delay_left <= delay_left - 1;
		end
	end

	//////////////////////////////////////////////////
	// stimulus and watchdog
	//////////////////////////////////////////////////

	task automatic run_slots(input int target, input logic random_stall);
		int unsigned r;
		while (slots_checked < target)
		begin
			@(posedge clock);
			r = lcg_next(stim_seed);
			stall <= random_stall && (r[17:16] == 2'b00);	// about one cycle in four
		end
	endtask

	initial
	begin
		fill_image();
		place_jump(64'h140, 64'h1c4, OP_BR);	// slot0 jump to an odd word
		place_jump(64'h1e4, 64'h160, OP_BSR);	// slot1 jump backward
		place_jump(64'h180, 64'h30c, OP_BR);	// way out of the backward loop
		place_jump(64'h604, 64'h700, OP_BSR);	// slot1 jump forward to a line start
		build_reference(`FETCH_RESET_VECTOR);
		while (reset !== 1'b0)
			@(posedge clock);
		test_name = "straight";
		run_slots(PHASE_SLOTS, 1'b0);
		test_name = "stall";
		run_slots(2 * PHASE_SLOTS, 1'b1);
		test_name = "redirect";
		for (int n = 0; n < REDIRECTS; n++)
		begin
			@(posedge clock);
			redirect <= 1'b1;
			redirect_pc <= random_target();
			@(posedge clock);
			redirect <= 1'b0;
			run_slots(slots_checked + REDIRECT_SLOTS, 1'b1);
		end
		$display("NO ERRORS");
		$finish;
	end

	initial
	begin
		repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clock);
		stop_with_failure($sformatf("timeout after %0d cycles, stream stopped early",
			WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
+incdir+include
hw/fetch_pkg.sv
hw/fetch_stage.sv
hw/icache.sv
hw/branch_predecode.sv
hw/fetch_unit.sv
test/clock_gen.sv
test/fetch_unit_assertions.sv
test/fetch_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = fetch_unit_tb
FILELIST = fetch_unit.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
FAIL_MSG = ERRORS FOUND
PASS_MSG = NO ERRORS
SOURCES = $(wildcard hw/*.sv test/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); \
	then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
